/* filelist.f */
logic/alu_ops_pkg.sv
logic/pipe_pkg.sv
logic/pipe_links.sv
logic/bypass_buffer.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/alu_pipe_top.sv
verif/alu_pipe_tb.sv

/* logic/alu_ops_pkg.sv */
`default_nettype none

package alu_ops_pkg;

    // Raw opcode field as it arrives at the pipeline input
    localparam int op_raw_width = 4;

    // Operations in raw code order, codes 0 to 7
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_sra = 3'd7
    } alu_op_e;

    // One bit per raw code, set where the code is a legal operation
    localparam logic [(1 << op_raw_width) - 1:0] op_legal_mask = 16'h00ff;

endpackage

`default_nettype wire

/* logic/alu_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top (
    input  wire                                   clk,
    input  wire                                   rst,

    input  wire [alu_ops_pkg::op_raw_width - 1:0] in_op,
    input  wire [pipe_pkg::data_width - 1:0]      in_a,
    input  wire [pipe_pkg::data_width - 1:0]      in_b,
    input  wire                                   in_valid,
    output logic                                  in_ready,

    output logic [pipe_pkg::data_width - 1:0]     out_value,
    output logic                                  out_zero,
    output logic                                  out_negative,
    output logic                                  out_illegal,
    output logic                                  out_valid,
    input  wire                                   out_ready
);

    decoded_if  dec_link ();
    executed_if exe_link ();

    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .op_raw (in_op),
        .a      (in_a),
        .b      (in_b),
        .valid  (in_valid),
        .ready  (in_ready),
        .dec    (dec_link)
    );

    execute_stage u_execute (
        .clk (clk),
        .rst (rst),
        .dec (dec_link),
        .exe (exe_link)
    );

    result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .out_ready    (out_ready),
        .exe          (exe_link),
        .out_value    (out_value),
        .out_zero     (out_zero),
        .out_negative (out_negative),
        .out_illegal  (out_illegal),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

/* logic/bypass_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module bypass_buffer #(
    parameter int WIDTH = 1
) (
    input  wire               clk,
    input  wire               rst,

    input  wire [WIDTH - 1:0] prev_data,
    input  wire               prev_valid,
    output logic              prev_ready,

    output logic [WIDTH - 1:0] next_data,
    output logic               next_valid,
    input  wire                next_ready
);

    logic [WIDTH - 1:0] store_q;
    logic               full_q;

    // Capture only while empty and the next stage is stalling
    always_ff @(posedge clk) begin
        if (!full_q && prev_valid && !next_ready) begin
            store_q <= prev_data;
        end
    end

    // Full stays set until the next stage takes the held item
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (!full_q) begin
            full_q <= prev_valid & ~next_ready;
        end else begin
            full_q <= ~next_ready;
        end
    end

    // Ready comes from the full flag only and never from next_ready
    assign prev_ready = ~full_q;

    assign next_data  = full_q ? store_q : prev_data;
    assign next_valid = full_q | prev_valid;

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                                clk,
    input  wire                                rst,

    input  wire [alu_ops_pkg::op_raw_width - 1:0] op_raw,
    input  wire [pipe_pkg::data_width - 1:0]      a,
    input  wire [pipe_pkg::data_width - 1:0]      b,
    input  wire                                   valid,
    output logic                                  ready,

    decoded_if.source                             dec
);

    localparam int payload_width = $bits(pipe_pkg::decoded_t);

    pipe_pkg::decoded_t payload;
    pipe_pkg::decoded_t buffered;
    logic               is_legal;

    assign is_legal = alu_ops_pkg::op_legal_mask[op_raw];

    // Legal codes map in order, illegal ones fall back to add
    always_comb begin
        payload.a       = a;
        payload.b       = b;
        payload.illegal = ~is_legal;
        if (is_legal) begin
            payload.op = alu_ops_pkg::alu_op_e'(op_raw[2:0]);
        end else begin
            payload.op = alu_ops_pkg::op_add;
        end
    end

    bypass_buffer #(
        .WIDTH (payload_width)
    ) u_dec_buffer (
        .clk        (clk),
        .rst        (rst),
        .prev_data  (payload),
        .prev_valid (valid),
        .prev_ready (ready),
        .next_data  (buffered),
        .next_valid (dec.valid),
        .next_ready (dec.ready)
    );

    assign dec.op      = buffered.op;
    assign dec.a       = buffered.a;
    assign dec.b       = buffered.b;
    assign dec.illegal = buffered.illegal;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire       clk,
    input  wire       rst,

    decoded_if.sink   dec,
    executed_if.source exe
);

    localparam int payload_width = $bits(pipe_pkg::executed_t);

    logic [pipe_pkg::data_width - 1:0]  alu_value;
    logic [pipe_pkg::shift_width - 1:0] shamt;

    pipe_pkg::executed_t res_q;
    pipe_pkg::executed_t buffered;
    logic                res_valid_q;
    logic                buf_ready;
    logic                res_taken;
    logic                load;

    assign shamt = dec.b[pipe_pkg::shift_width - 1:0];

    always_comb begin
        case (dec.op)
            alu_ops_pkg::op_add: alu_value = dec.a + dec.b;
            alu_ops_pkg::op_sub: alu_value = dec.a - dec.b;
            alu_ops_pkg::op_and: alu_value = dec.a & dec.b;
            alu_ops_pkg::op_or:  alu_value = dec.a | dec.b;
            alu_ops_pkg::op_xor: alu_value = dec.a ^ dec.b;
            alu_ops_pkg::op_sll: alu_value = dec.a << shamt;
            alu_ops_pkg::op_srl: alu_value = dec.a >> shamt;
            alu_ops_pkg::op_sra: alu_value = $unsigned($signed(dec.a) >>> shamt);
            default:             alu_value = '0;
        endcase
        // Illegal items carry a zero value
        if (dec.illegal) begin
            alu_value = '0;
        end
    end

    // Register may reload in the same cycle its item moves on
    assign res_taken = res_valid_q & buf_ready;
    assign dec.ready = ~res_valid_q | res_taken;
    assign load      = dec.valid & dec.ready;

    always_ff @(posedge clk) begin
        if (load) begin
            res_q.value   <= alu_value;
            res_q.illegal <= dec.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_q <= 1'b0;
        end else if (load) begin
            res_valid_q <= 1'b1;
        end else if (res_taken) begin
            res_valid_q <= 1'b0;
        end
    end

    bypass_buffer #(
        .WIDTH (payload_width)
    ) u_exe_buffer (
        .clk        (clk),
        .rst        (rst),
        .prev_data  (res_q),
        .prev_valid (res_valid_q),
        .prev_ready (buf_ready),
        .next_data  (buffered),
        .next_valid (exe.valid),
        .next_ready (exe.ready)
    );

    assign exe.value   = buffered.value;
    assign exe.illegal = buffered.illegal;

endmodule

`default_nettype wire

/* logic/pipe_links.sv */
`timescale 1ns/1ps
`default_nettype none

// Link from decode into execute
interface decoded_if;

    alu_ops_pkg::alu_op_e              op;
    logic [pipe_pkg::data_width - 1:0] a;
    logic [pipe_pkg::data_width - 1:0] b;
    logic                              illegal;
    logic                              valid;
    logic                              ready;

    modport source (output op, a, b, illegal, valid, input ready);
    modport sink   (input op, a, b, illegal, valid, output ready);

endinterface

// Link from execute into result
interface executed_if;

    logic [pipe_pkg::data_width - 1:0] value;
    logic                              illegal;
    logic                              valid;
    logic                              ready;

    modport source (output value, illegal, valid, input ready);
    modport sink   (input value, illegal, valid, output ready);

endinterface

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int data_width  = 32;

    // Low bits of operand b that form the shift amount
    localparam int shift_width = 5;

    // Decode to execute payload
    typedef struct packed {
        alu_ops_pkg::alu_op_e    op;
        logic [data_width - 1:0] a;
        logic [data_width - 1:0] b;
        logic                    illegal;
    } decoded_t;

    // Execute to result payload
    typedef struct packed {
        logic [data_width - 1:0] value;
        logic                    illegal;
    } executed_t;

endpackage

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               out_ready,

    executed_if.sink                          exe,

    output logic [pipe_pkg::data_width - 1:0] out_value,
    output logic                              out_zero,
    output logic                              out_negative,
    output logic                              out_illegal,
    output logic                              out_valid
);

    logic load;

    // Accept when empty or when the held result leaves this cycle
    assign exe.ready = ~out_valid | out_ready;
    assign load      = exe.valid & exe.ready;

    // Flags derived at load time, held with the value under stall
    always_ff @(posedge clk) begin
        if (load) begin
            out_value    <= exe.value;
            out_zero     <= (exe.value == '0);
            out_negative <= exe.value[pipe_pkg::data_width - 1];
            out_illegal  <= exe.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with assertions enabled
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module alu_pipe_tb -f filelist.f -o alu_pipe_sim

# Exit status is nonzero when the run ends in $fatal
./obj_dir/alu_pipe_sim

/* verif/alu_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_tb;

    localparam int   num_random  = 280;
    localparam int   num_burst   = 20;
    localparam int   num_items   = num_random + num_burst;
    localparam real  clk_period  = 20.0;

    typedef struct packed {
        logic [31:0] value;
        logic        zero;
        logic        negative;
        logic        illegal;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [3:0]  in_op = '0;
    logic [31:0] in_a = '0;
    logic [31:0] in_b = '0;
    logic        in_valid = 1'b0;
    logic        in_ready;
    logic [31:0] out_value;
    logic        out_zero;
    logic        out_negative;
    logic        out_illegal;
    logic        out_valid;
    logic        out_ready = 1'b0;

    integer      seed = 49585;
    expect_t     exp_q[$];
    expect_t     head = '0;
    logic        head_valid = 1'b0;
    expect_t     in_exp;
    logic        burst_mode = 1'b0;
    logic        burst_fire;
    int          in_count = 0;
    int          out_count = 0;

    alu_pipe_top alu_pipe_top_i (
        .clk          (clk),
        .rst          (rst),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_value    (out_value),
        .out_zero     (out_zero),
        .out_negative (out_negative),
        .out_illegal  (out_illegal),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    // Reference model from the operation rules
    // Raw codes 8 and up give an illegal zero result
    function automatic expect_t expected_result(input logic [3:0] op, input logic [31:0] a,
                                                input logic [31:0] b);
        expect_t            r;
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        r.illegal = op[3];
        case (op)
            4'd0: r.value = a + b;
            4'd1: r.value = a - b;
            4'd2: r.value = a & b;
            4'd3: r.value = a | b;
            4'd4: r.value = a ^ b;
            4'd5: r.value = a << sh;
            4'd6: r.value = a >> sh;
            4'd7: r.value = sa >>> sh;
            default: r.value = 32'd0;
        endcase
        r.zero     = (r.value == 32'd0);
        r.negative = r.value[31];
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Holds the item until accepted
    // in_ready only moves on the rising edge
    task automatic send_item(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        in_op    = op;
        in_a     = a;
        in_b     = b;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        exp_q.push_back(expected_result(op, a, b));
        in_count++;
        @(posedge clk);
    endtask

    always_comb in_exp = expected_result(in_op, in_a, in_b);
    assign burst_fire = burst_mode && in_valid && in_ready;

    always @(negedge clk) begin
        if (burst_mode) begin
            out_ready = 1'b1;
        end else begin
            out_ready = ({$random(seed)} % 3) != 0;
        end
        head_valid = exp_q.size() > 0;
        if (head_valid) begin
            head = exp_q[0];
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            out_count++;
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid && in_ready)
        else report_failure("out_valid or in_ready wrong after reset");
    a_expected: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> head_valid)
        else report_failure("output handshake with no item expected");
    a_value: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && head_valid |-> out_value == head.value)
        else report_failure($sformatf("out_value %h, expected %h",
                                      $sampled(out_value), head.value));
    a_illegal: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && head_valid |-> out_illegal == head.illegal)
        else report_failure("out_illegal does not match the opcode");
    a_flags: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && head_valid |->
        out_zero == head.zero && out_negative == head.negative)
        else report_failure("out_zero or out_negative wrong for the value");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_value) && $stable(out_zero)
        && $stable(out_negative) && $stable(out_illegal))
        else report_failure("output changed while stalled");
    a_latency: assert property (@(posedge clk) disable iff (rst)
        $past(burst_fire, 2) |-> out_valid && out_value == $past(in_exp.value, 2))
        else report_failure("burst item not at the output two edges after input");

    // Watchdog sized for every item taking 20 cycles
    initial begin
        #(num_items * 20 * clk_period);
        $display("Timeout: the pipeline did not finish all items in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  op;
        int          gap;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_random; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            op  = rnd[3:0];
            // Equal operands with sub or xor force a zero result
            if (rnd[7:5] == 3'd0) begin
                b  = a;
                op = rnd[4] ? 4'd1 : 4'd4;
            end
            gap = rnd[9:8] == 2'd3 ? 2 : rnd[9:8];
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            send_item(op, a, b);
        end
        @(negedge clk);
        in_valid = 1'b0;

        // Drain, then stream back to back with out_ready held high
        burst_mode = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
        for (int i = 0; i < num_burst; i++) begin
            send_item(4'(i), $random(seed), $random(seed));
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        if (in_count == out_count && exp_q.size() == 0 && in_count == num_items) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure($sformatf("%0d items in, %0d out", in_count, out_count));
        end
    end

endmodule

`default_nettype wire
